/* roi_pkg.sv */
package roi_pkg;

	// =========================================================================
	// Basic types
	// =========================================================================
	typedef logic [15:0] coord_t;      // Column or row index
	typedef logic [31:0] wb_data_t;    // Wishbone data
	typedef logic [2:0]  wb_addr_t;    // Wishbone word address

	localparam int WINDOW_LEN = 128;          // Sliding window length in pixels
	typedef logic [WINDOW_LEN-1:0] window_t;  // Oldest pixel in the MSB, newest in bit 0

	typedef struct packed {
		logic fval;   // Frame valid
		logic lval;   // Line valid
		logic pix;    // Thresholded pixel, 1 = white
	} pix_in_t;

	typedef struct packed {
		coord_t col;
		coord_t row;
		logic   valid;   // Pixel at col/row seen on the last edge
	} raster_pos_t;

	typedef struct packed {
		logic all_white;   // Whole window white
		logic top_left;    // White then short black run
		logic left_run;    // Left edge of the dark area
		logic right_run;   // Right edge of the dark area
	} edge_flags_t;

	typedef struct packed {
		coord_t top;
		coord_t left;
		coord_t right;
		coord_t bottom;
	} roi_result_t;

	typedef enum logic [2:0] {
		seek_blank,     // Wait for the white field
		seek_top,       // First white/black edge
		seek_left,      // Left edge a few rows down
		seek_right,     // Right edge on the same rows
		track_bottom,   // Follow the edges down
		hold            // Done until frame end
	} roi_state_t;

	// =========================================================================
	// Edge patterns, oldest pixel first
	// =========================================================================
	localparam int TL_WHITE_LEN = 104;
	localparam int TL_BLACK_LEN = 24;
	localparam int LR_WHITE_LEN = 100;
	localparam int LR_BLACK_LEN = 28;
	localparam int RR_BLACK_LEN = 28;
	localparam int RR_WHITE_LEN = 100;

	localparam window_t PAT_ALL_WHITE = '1;
	localparam window_t PAT_TOP_LEFT  = {{TL_WHITE_LEN{1'b1}}, {TL_BLACK_LEN{1'b0}}};
	localparam window_t PAT_LEFT_RUN  = {{LR_WHITE_LEN{1'b1}}, {LR_BLACK_LEN{1'b0}}};
	localparam window_t PAT_RIGHT_RUN = {{RR_BLACK_LEN{1'b0}}, {RR_WHITE_LEN{1'b1}}};

	localparam coord_t ROW_MARGIN = 16'd50;   // Border rows ignored at top and bottom
	localparam coord_t TOP_SKIP   = 16'd24;   // Rows below top before left/right search

	// Register map, word addresses
	localparam wb_addr_t REG_STATUS = 3'd0;   // Bit 0 done, bits 3:1 state
	localparam wb_addr_t REG_TOP    = 3'd1;
	localparam wb_addr_t REG_LEFT   = 3'd2;
	localparam wb_addr_t REG_RIGHT  = 3'd3;
	localparam wb_addr_t REG_BOTTOM = 3'd4;

endpackage

/* raster_counter.sv */
`timescale 1ns/100ps

module raster_counter
	import roi_pkg::*;
#(
	parameter int IMG_WIDTH  = 1280,
	parameter int IMG_HEIGHT = 960
) (
	input  logic        CCD_PIXCLK,
	input  logic        DLY_RST_1,
	input  pix_in_t     pix,
	output raster_pos_t pos
);

	coord_t col_cnt;     // Index the next valid pixel gets
	coord_t row_cnt;     // Current line in the frame
	logic   lval_q;      // Line valid one cycle back
	logic   pix_valid;
	logic   line_fall;

	always_comb begin
		pix_valid = pix.fval & pix.lval;
		line_fall = lval_q & ~pix.lval;   // Last edge ended a line
	end

	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			col_cnt <= '0;
			row_cnt <= '0;
			lval_q  <= 1'b0;
			pos     <= '0;
		end else begin
			lval_q <= pix.lval;
			if (!pix.fval) begin   // Frame blanking, start over
				col_cnt <= '0;
				row_cnt <= '0;
				pos     <= '0;
			end else begin
				pos.valid <= pix_valid;
				if (pix_valid) begin
					pos.col <= col_cnt;   // Position of this pixel
					pos.row <= row_cnt;
					if (col_cnt != coord_t'(IMG_WIDTH))
						col_cnt <= col_cnt + 1'b1;   // Saturates at the width
				end else begin
					col_cnt <= '0;   // Line blanking
				end
				if (line_fall && row_cnt != coord_t'(IMG_HEIGHT))
					row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	// A line longer than the image shows up as an out-of-range column
	assert property (@(posedge CCD_PIXCLK) disable iff (!DLY_RST_1)
		pos.valid |-> pos.col < coord_t'(IMG_WIDTH))
		else $error("raster_counter: line longer than %0d pixels", IMG_WIDTH);

endmodule

/* edge_window.sv */
`timescale 1ns/100ps

module edge_window
	import roi_pkg::*;
(
	input  logic        CCD_PIXCLK,
	input  logic        DLY_RST_1,
	input  pix_in_t     pix,
	output edge_flags_t flags,
	output logic        line_end
);

	localparam int FILL_W = $clog2(WINDOW_LEN + 1);

	window_t           win;        // Last WINDOW_LEN pixels of the line
	window_t           win_next;   // Window including the pixel on the input
	logic [FILL_W-1:0] fill;       // Line pixels held, saturating
	logic              full_next;  // Window full once this pixel is in
	logic              lval_q;
	logic              pix_valid;

	always_comb begin
		pix_valid = pix.fval & pix.lval;
		win_next  = {win[WINDOW_LEN-2:0], pix.pix};   // Shift in at the LSB
		full_next = fill >= FILL_W'(WINDOW_LEN - 1);
	end

	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			win      <= '0;
			fill     <= '0;
			lval_q   <= 1'b0;
			line_end <= 1'b0;
			flags    <= '0;
		end else begin
			lval_q   <= pix.lval;
			line_end <= lval_q & ~pix.lval;   // One cycle after line valid falls
			if (pix_valid) begin
				win <= win_next;
				if (fill != FILL_W'(WINDOW_LEN))
					fill <= fill + 1'b1;
				// Patterns only count over pixels of the current line
				flags.all_white <= full_next && (win_next == PAT_ALL_WHITE);
				flags.top_left  <= full_next && (win_next == PAT_TOP_LEFT);
				flags.left_run  <= full_next && (win_next == PAT_LEFT_RUN);
				flags.right_run <= full_next && (win_next == PAT_RIGHT_RUN);
			end else begin
				win   <= '0;   // Blanking empties the window
				fill  <= '0;
				flags <= '0;
			end
		end
	end

endmodule

/* roi_tracker.sv */
`timescale 1ns/100ps

module roi_tracker
	import roi_pkg::*;
#(
	parameter int IMG_WIDTH  = 1280,
	parameter int IMG_HEIGHT = 960
) (
	input  logic        CCD_PIXCLK,
	input  logic        DLY_RST_1,
	input  raster_pos_t pos,
	input  edge_flags_t flags,
	input  logic        line_end,
	input  logic        frame_valid,
	output roi_result_t res,
	output roi_state_t  state,
	output logic        found
);

	localparam coord_t HALF_COL = coord_t'(IMG_WIDTH / 2);
	localparam coord_t ROW_HI   = coord_t'(IMG_HEIGHT) - ROW_MARGIN;

	logic        fval_q;
	logic        frame_end;     // Falling frame valid
	logic        left_seen;     // Left edge seen on this line
	logic        right_seen;    // Right edge seen on this line
	edge_flags_t hit;           // Flags of a valid pixel only
	logic        row_in;
	logic        left_half;
	logic        right_half;
	logic        beyond_skip;   // Far enough below top for left/right
	logic        beyond_top;

	always_comb begin
		frame_end   = fval_q & ~frame_valid;
		hit         = pos.valid ? flags : '0;
		row_in      = (pos.row > ROW_MARGIN) && (pos.row < ROW_HI);
		left_half   = pos.col < HALF_COL;
		right_half  = pos.col > HALF_COL;
		beyond_skip = pos.row > res.top + TOP_SKIP;
		beyond_top  = pos.row > res.top;
	end

	// =========================================================================
	// ROI state machine
	// =========================================================================
	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			state      <= seek_blank;
			res        <= '0;
			found      <= 1'b0;
			fval_q     <= 1'b0;
			left_seen  <= 1'b0;
			right_seen <= 1'b0;
		end else begin
			fval_q <= frame_valid;
			found  <= 1'b0;
			if (frame_end) begin   // Results stay for the bus
				state      <= seek_blank;
				left_seen  <= 1'b0;
				right_seen <= 1'b0;
			end else begin
				case (state)
					seek_blank: begin
						if (hit.all_white)
							state <= seek_top;   // On the white field
					end
					seek_top: begin
						if (hit.top_left && row_in && left_half) begin
							res.top <= pos.row;
							state   <= seek_left;
						end
					end
					seek_left: begin
						if (hit.top_left && left_half && beyond_skip && row_in) begin
							res.left <= pos.col;
							state    <= seek_right;
						end
					end
					seek_right: begin
						// Last match on the line wins
						if (hit.right_run && right_half && beyond_skip && row_in)
							res.right <= pos.col;
						if (line_end)
							state <= track_bottom;
					end
					track_bottom: begin
						if (hit.left_run && left_half && beyond_top && row_in)
							left_seen <= 1'b1;
						if (hit.right_run && right_half && beyond_top && row_in)
							right_seen <= 1'b1;
						if (line_end) begin
							if (!left_seen && !right_seen) begin   // Edges gone
								res.bottom <= pos.row - 1'b1;       // Last row with edges
								state      <= hold;
								found      <= 1'b1;
							end
							left_seen  <= 1'b0;
							right_seen <= 1'b0;
						end
					end
					hold: begin
						state <= hold;   // Until frame valid drops
					end
					default: state <= seek_blank;
				endcase
			end
		end
	end

	// Found only on the step from track_bottom into hold
	assert property (@(posedge CCD_PIXCLK) disable iff (!DLY_RST_1)
		found |-> (state == hold) && ($past(state) == track_bottom))
		else $error("roi_tracker: found outside entry to hold");

endmodule

/* roi_regs.sv */
`timescale 1ns/100ps

module roi_regs
	import roi_pkg::*;
(
	input  logic        CCD_PIXCLK,
	input  logic        DLY_RST_1,
	input  roi_result_t res,
	input  roi_state_t  state,
	input  logic        found,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  wb_addr_t    wb_adr,
	input  wb_data_t    wb_dat_w,
	output logic        wb_ack,
	output wb_data_t    wb_dat_r
);

	logic     done;     // Sticky, set by found
	logic     req;      // Bus cycle active
	logic     clr_wr;   // Clear request on status
	wb_data_t rd_mux;

	always_comb begin
		req    = wb_cyc & wb_stb;
		clr_wr = req & wb_we & ~wb_ack & (wb_adr == REG_STATUS) & wb_dat_w[0];
		case (wb_adr)
			REG_STATUS: rd_mux = wb_data_t'({state, done});
			REG_TOP:    rd_mux = wb_data_t'(res.top);    // Zero extended
			REG_LEFT:   rd_mux = wb_data_t'(res.left);
			REG_RIGHT:  rd_mux = wb_data_t'(res.right);
			REG_BOTTOM: rd_mux = wb_data_t'(res.bottom);
			default:    rd_mux = '0;
		endcase
	end

	always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			done   <= 1'b0;
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;   // One cycle behind cyc and stb
			if (found)
				done <= 1'b1;   // Wins over a clear
			else if (clr_wr)
				done <= 1'b0;
		end
	end

	// Read data follows the address while the cycle is open
	always_ff @(posedge CCD_PIXCLK) begin
		if (req)
			wb_dat_r <= rd_mux;
	end

	// Ack only answers a strobe from the cycle before
	assert property (@(posedge CCD_PIXCLK) disable iff (!DLY_RST_1)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("roi_regs: ack without strobe");

endmodule

/* roi_finder_top.sv */
`timescale 1ns/100ps

module roi_finder_top
	import roi_pkg::*;
#(
	parameter int IMG_WIDTH  = 1280,
	parameter int IMG_HEIGHT = 960
) (
	input  logic     CCD_PIXCLK,
	input  logic     DLY_RST_1,
	input  pix_in_t  pix,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_w,
	output logic     wb_ack,
	output wb_data_t wb_dat_r
);

	raster_pos_t pos;        // Position of the last pixel
	edge_flags_t flags;      // Pattern hits for the same pixel
	logic        line_end;
	roi_result_t res;
	roi_state_t  state;
	logic        found;

	// Counter and window see the same pixel on the same edge
	raster_counter #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) u_raster (
		.CCD_PIXCLK (CCD_PIXCLK),
		.DLY_RST_1  (DLY_RST_1),
		.pix        (pix),
		.pos        (pos)
	);

	edge_window u_window (
		.CCD_PIXCLK (CCD_PIXCLK),
		.DLY_RST_1  (DLY_RST_1),
		.pix        (pix),
		.flags      (flags),
		.line_end   (line_end)
	);

	roi_tracker #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) u_tracker (
		.CCD_PIXCLK  (CCD_PIXCLK),
		.DLY_RST_1   (DLY_RST_1),
		.pos         (pos),
		.flags       (flags),
		.line_end    (line_end),
		.frame_valid (pix.fval),
		.res         (res),
		.state       (state),
		.found       (found)
	);

	roi_regs u_regs (
		.CCD_PIXCLK (CCD_PIXCLK),
		.DLY_RST_1  (DLY_RST_1),
		.res        (res),
		.state      (state),
		.found      (found),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_ack     (wb_ack),
		.wb_dat_r   (wb_dat_r)
	);

endmodule

/* roi_checker.sv */
`timescale 1ns/100ps

module roi_checker
	import roi_pkg::*;
#(
	parameter int IMG_WIDTH  = 1280,
	parameter int IMG_HEIGHT = 960
) (
	input  logic     CCD_PIXCLK,
	input  logic     DLY_RST_1,
	input  pix_in_t  pix,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_w,
	input  logic     wb_ack,
	input  wb_data_t wb_dat_r,
	output int       error_count,
	output int       read_count,
	output int       cycle_count,
	output int       ack_count
);

	localparam int MARGIN = 50;               // Border rows
	localparam int SKIP   = 24;               // Rows below top before left/right
	localparam int HALF   = IMG_WIDTH / 2;
	localparam int ROW_HI = IMG_HEIGHT - MARGIN;

	// Window patterns, oldest pixel in the MSB
	localparam logic [127:0] P_WHITE     = {128{1'b1}};
	localparam logic [127:0] P_TOP_LEFT  = {{104{1'b1}}, {24{1'b0}}};
	localparam logic [127:0] P_LEFT_RUN  = {{100{1'b1}}, {28{1'b0}}};
	localparam logic [127:0] P_RIGHT_RUN = {{28{1'b0}}, {100{1'b1}}};

	// Tracker states, numbered as in the status register
	localparam int S_BLANK  = 0;
	localparam int S_TOP    = 1;
	localparam int S_LEFT   = 2;
	localparam int S_RIGHT  = 3;
	localparam int S_BOTTOM = 4;
	localparam int S_HOLD   = 5;

	localparam logic [2:0] A_STATUS = 3'd0;
	localparam logic [2:0] A_TOP    = 3'd1;
	localparam logic [2:0] A_LEFT   = 3'd2;
	localparam logic [2:0] A_RIGHT  = 3'd3;
	localparam logic [2:0] A_BOTTOM = 3'd4;

	logic [127:0] win = '0;      // Model window, newest in bit 0
	int           fill = 0;
	int           col = 0;
	int           row = 0;
	int           last_row = 0;  // Row of the last valid pixel
	logic         fval_q = 1'b0;
	logic         lval_q = 1'b0;
	logic         req_q = 1'b0;
	int           m_state = 0;
	int           m_top = 0;
	int           m_left = 0;
	int           m_right = 0;
	int           m_bottom = 0;
	logic         m_done = 1'b0;
	logic         left_seen = 1'b0;
	logic         right_seen = 1'b0;
	int           errors = 0;
	int           reads = 0;
	int           cycles = 0;
	int           acks = 0;

	assign error_count = errors;
	assign read_count  = reads;
	assign cycle_count = cycles;
	assign ack_count   = acks;

	function automatic string reg_name(input logic [2:0] adr);
		case (adr)
			A_STATUS: return "status";
			A_TOP:    return "top";
			A_LEFT:   return "left";
			A_RIGHT:  return "right";
			A_BOTTOM: return "bottom";
			default:  return "unmapped";
		endcase
	endfunction

	function automatic logic [31:0] expected_reg(input logic [2:0] adr);
		case (adr)
			A_STATUS: return 32'(m_state * 2) | 32'(m_done);   // State above done
			A_TOP:    return 32'(m_top);
			A_LEFT:   return 32'(m_left);
			A_RIGHT:  return 32'(m_right);
			A_BOTTOM: return 32'(m_bottom);
			default:  return 32'h0;
		endcase
	endfunction

	// =========================================================================
	// Tracker rules, one valid pixel at a time
	// =========================================================================
	task automatic pixel_rule(input int c, input int r, input bit aw, input bit tl,
		input bit lr, input bit rr);
		bit row_in;
		bit lh;
		bit rh;
		row_in = (r > MARGIN) && (r < ROW_HI);
		lh     = c < HALF;
		rh     = c > HALF;
		case (m_state)
			S_BLANK: if (aw) m_state = S_TOP;
			S_TOP: begin
				if (tl && row_in && lh) begin
					m_top   = r;
					m_state = S_LEFT;
				end
			end
			S_LEFT: begin
				if (tl && lh && r > m_top + SKIP && row_in) begin
					m_left  = c;
					m_state = S_RIGHT;
				end
			end
			S_RIGHT: if (rr && rh && r > m_top + SKIP && row_in) m_right = c;   // Last one wins
			S_BOTTOM: begin
				if (lr && lh && r > m_top && row_in)
					left_seen = 1'b1;
				if (rr && rh && r > m_top && row_in)
					right_seen = 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic line_rule();
		if (m_state == S_RIGHT) begin
			m_state = S_BOTTOM;
		end else if (m_state == S_BOTTOM) begin
			if (!left_seen && !right_seen) begin   // First line without edges
				m_bottom = last_row - 1;
				m_state  = S_HOLD;
				m_done   = 1'b1;
			end
			left_seen  = 1'b0;
			right_seen = 1'b0;
		end
	endtask

	task automatic step_model();
		logic valid;
		valid = pix.fval && pix.lval;
		if (fval_q && !pix.fval) begin   // Frame end, results kept
			m_state    = S_BLANK;
			left_seen  = 1'b0;
			right_seen = 1'b0;
		end else if (lval_q && !pix.lval) begin
			line_rule();
			if (pix.fval)
				row++;
		end
		if (valid) begin
			win = {win[126:0], pix.pix};
			if (fill < 128)
				fill++;
			pixel_rule(col, row, fill == 128 && win == P_WHITE,
				fill == 128 && win == P_TOP_LEFT, fill == 128 && win == P_LEFT_RUN,
				fill == 128 && win == P_RIGHT_RUN);
			last_row = row;
			col++;
		end else begin
			win  = '0;   // Blanking
			fill = 0;
			col  = 0;
		end
		if (!pix.fval)
			row = 0;
		fval_q = pix.fval;
		lval_q = pix.lval;
	endtask

	// =========================================================================
	// Bus monitor
	// =========================================================================
	task automatic check_bus();
		logic        req;
		logic [31:0] exp;
		req = wb_cyc && wb_stb;
		if (req && !req_q)
			cycles++;   // New cycle opened
		if (wb_ack && !req_q) begin
			errors++;
			$display("%0t: acknowledge came without a strobe in the cycle before", $time);
		end
		if (wb_ack && req) begin
			acks++;
			if (wb_we) begin
				if (wb_adr == A_STATUS && wb_dat_w[0])
					m_done = 1'b0;   // Clear of done
			end else begin
				exp = expected_reg(wb_adr);
				reads++;
				if (wb_dat_r !== exp) begin
					errors++;
					$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
						$time, reg_name(wb_adr), exp, wb_dat_r);
				end
			end
		end
		req_q = req;
	endtask

	always @(posedge CCD_PIXCLK or negedge DLY_RST_1) begin
		if (!DLY_RST_1) begin
			win        = '0;
			fill       = 0;
			col        = 0;
			row        = 0;
			fval_q     = 1'b0;
			lval_q     = 1'b0;
			req_q      = 1'b0;
			m_state    = S_BLANK;
			m_top      = 0;
			m_left     = 0;
			m_right    = 0;
			m_bottom   = 0;
			m_done     = 1'b0;
			left_seen  = 1'b0;
			right_seen = 1'b0;
		end else begin
			check_bus();    // Against the model before this edge
			step_model();
		end
	end

endmodule

/* tb_top.sv */
`timescale 1ns/100ps

module tb_top
	import roi_pkg::*;
();

	localparam int IMG_WIDTH    = 400;
	localparam int IMG_HEIGHT   = 200;
	localparam int CLK_PERIOD   = 20;
	localparam int N_FRAMES     = 12;
	localparam int LINE_BLANK   = 8;
	localparam int FRAME_BLANK  = 10;
	localparam int FRAME_CYCLES = IMG_HEIGHT * (IMG_WIDTH + LINE_BLANK) + FRAME_BLANK;
	localparam int WATCHDOG_NS  = N_FRAMES * FRAME_CYCLES * CLK_PERIOD * 3 / 2;
	localparam int BUS_TIMEOUT  = 16;   // Cycles to wait for ack

	localparam int K_BLACK = 0;   // Frame kinds
	localparam int K_WHITE = 1;
	localparam int K_RECT  = 2;

	logic        CCD_PIXCLK;
	logic        DLY_RST_1;
	pix_in_t     pix;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	wb_addr_t    wb_adr;
	wb_data_t    wb_dat_w;
	logic        wb_ack;
	wb_data_t    wb_dat_r;
	int          error_count;
	int          read_count;
	int          cycle_count;
	int          ack_count;
	logic [31:0] seed = 32'h120d_317f;
	int          kind = K_RECT;
	int          r_top = 0;
	int          r_left = 0;
	int          r_right = 0;
	int          r_bottom = 0;
	int          noise_rate = 0;   // Flips per 4096 pixels
	int          bus_errors = 0;
	int          reads_issued = 0;

	roi_finder_top #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) UUT (
		.CCD_PIXCLK (CCD_PIXCLK),
		.DLY_RST_1  (DLY_RST_1),
		.pix        (pix),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_ack     (wb_ack),
		.wb_dat_r   (wb_dat_r)
	);

	roi_checker #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) u_checker (
		.CCD_PIXCLK  (CCD_PIXCLK),
		.DLY_RST_1   (DLY_RST_1),
		.pix         (pix),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_ack      (wb_ack),
		.wb_dat_r    (wb_dat_r),
		.error_count (error_count),
		.read_count  (read_count),
		.cycle_count (cycle_count),
		.ack_count   (ack_count)
	);

	initial begin
		CCD_PIXCLK = 1'b0;
		forever #(CLK_PERIOD / 2) CCD_PIXCLK = ~CCD_PIXCLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// =========================================================================
	// Stimulus helpers
	// =========================================================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int draw(input int lo, input int hi);
		seed = xorshift(seed);
		return lo + int'(seed % 32'(hi - lo + 1));
	endfunction

	function automatic logic pixel_value(input int r, input int c);
		logic dark;
		dark = (kind == K_BLACK) || (kind == K_RECT && r >= r_top && r <= r_bottom &&
			c >= r_left && c <= r_right);
		return !dark;   // 1 = white
	endfunction

	task automatic next_cycle();
		@(posedge CCD_PIXCLK);
		#2;
	endtask

	task automatic bus_access(input wb_addr_t adr, input logic we, input wb_data_t data);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (!wb_ack && n < BUS_TIMEOUT);
		if (!wb_ack) begin
			bus_errors++;
			$display("%0t: bus access to address %0d was never acknowledged", $time, adr);
		end
		next_cycle();   // Ack taken on this edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		next_cycle();   // Idle cycle, ack falls
	endtask

	task automatic read_all();
		bus_access(REG_STATUS, 1'b0, '0);
		bus_access(REG_TOP, 1'b0, '0);
		bus_access(REG_LEFT, 1'b0, '0);
		bus_access(REG_RIGHT, 1'b0, '0);
		bus_access(REG_BOTTOM, 1'b0, '0);
		reads_issued += 5;
	endtask

	task automatic pick_frame(input int f);
		int sel;
		sel        = draw(0, 7);
		kind       = (sel == 0) ? K_BLACK : (sel == 1) ? K_WHITE : K_RECT;
		r_top      = draw(55, 90);
		r_bottom   = r_top + draw(30, 50);
		r_left     = draw(110, 170);
		r_right    = r_left + draw(40, 120);   // Leaves room for the right run
		sel        = draw(0, 3);
		noise_rate = (sel == 0) ? 0 : (sel == 1) ? 1 : (sel == 2) ? 3 : 8;
		if (f == 0) begin   // Clean rectangle first
			kind       = K_RECT;
			noise_rate = 0;
		end
		$display("Frame %0d kind %0d rows %0d-%0d cols %0d-%0d noise %0d", f, kind,
			r_top, r_bottom, r_left, r_right, noise_rate);
	endtask

	task automatic send_frame();
		int r;
		int c;
		logic flip;
		for (r = 0; r < IMG_HEIGHT; r++) begin
			for (c = 0; c < IMG_WIDTH; c++) begin
				flip     = (noise_rate != 0) && (draw(0, 4095) < noise_rate);
				pix.fval = 1'b1;
				pix.lval = 1'b1;
				pix.pix  = pixel_value(r, c) ^ flip;
				next_cycle();
			end
			pix.lval = 1'b0;   // Line blanking
			pix.pix  = 1'b0;
			repeat (LINE_BLANK) next_cycle();
		end
		pix = '0;
		repeat (FRAME_BLANK) next_cycle();
	endtask

	// =========================================================================
	// Main sequence
	// =========================================================================
	initial begin
		int f;
		int total;
		pix       = '0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		DLY_RST_1 = 1'b0;
		repeat (8) @(posedge CCD_PIXCLK);
		#2;
		DLY_RST_1 = 1'b1;
		next_cycle();
		read_all();   // All zero out of reset
		for (f = 0; f < N_FRAMES; f++) begin
			pick_frame(f);
			send_frame();
			read_all();   // Still in frame blanking
			if (f % 2 == 1) begin
				bus_access(REG_STATUS, 1'b1, 32'h1);
				bus_access(REG_STATUS, 1'b0, '0);
				reads_issued++;
			end
		end
		next_cycle();
		total = error_count + bus_errors;
		if (cycle_count != ack_count) begin
			total++;
			$display("Bus cycles opened %0d but acknowledged %0d", cycle_count, ack_count);
		end
		if (read_count != reads_issued) begin
			total++;
			$display("Checker saw %0d reads, bench issued %0d", read_count, reads_issued);
		end
		$display("Errors %0d: checker %0d, bus timeouts %0d, reads checked %0d", total,
			error_count, bus_errors, read_count);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* tb.f */
roi_pkg.sv
raster_counter.sv
edge_window.sv
roi_tracker.sv
roi_regs.sv
roi_finder_top.sv
roi_checker.sv
tb_top.sv

/* Makefile */
# Verilator build and run of the ROI finder testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
